// ==== common/lsu_pkg.sv ====
// shared types, funct3 width codes and enums for the load/store unit, imported by every block

package lsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths with a meaning
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] word_t;   // data word, store/load/memory data
  typedef logic [31:0] addr_t;   // byte address
  typedef logic [3:0]  ben_t;    // one enable per byte lane
  typedef logic [1:0]  boff_t;   // byte offset inside a word
  typedef logic [2:0]  funct3_t; // riscv load/store width code

  ////////////////////////////////////////////////////////////////////////////
  // funct3 width codes
  ////////////////////////////////////////////////////////////////////////////

  // stores only use the first three
  localparam funct3_t F3_B  = 3'd0; // byte, signed on load
  localparam funct3_t F3_H  = 3'd1; // halfword, signed on load
  localparam funct3_t F3_W  = 3'd2; // full word
  localparam funct3_t F3_BU = 3'd4; // byte, zero extended
  localparam funct3_t F3_HU = 3'd5; // halfword, zero extended

  ////////////////////////////////////////////////////////////////////////////
  // enums
  ////////////////////////////////////////////////////////////////////////////

  // response status, illegal wins over misaligned
  typedef enum logic [1:0] {
    ST_OK         = 2'd0,
    ST_MISALIGNED = 2'd1,
    ST_ILLEGAL    = 2'd2
  } lsu_status_t;

  // control fsm
  typedef enum logic [1:0] {
    S_IDLE    = 2'd0, // waiting for a request
    S_ACCESS  = 2'd1, // check cycle, then bus access
    S_RESPOND = 2'd2  // response held until rsp_ready
  } lsu_state_t;

endpackage

// ==== lsu/lsu_ctrl.sv ====
// load/store control FSM, holds the request register and drives both handshakes and the bus strobe
`timescale 1ns/100ps

module lsu_ctrl import lsu_pkg::*; #(
  parameter int unsigned MEM_WORDS = 256  // memory depth in words
)(
  input  logic                         clk,
  input  logic                         rst,
  // core request
  input  logic                         req_valid,
  output logic                         req_ready,
  input  logic                         req_store,
  input  funct3_t                      req_funct3,
  input  addr_t                        req_addr,
  input  word_t                        req_wdata,
  // core response
  output logic                         rsp_valid,
  input  logic                         rsp_ready,
  output lsu_status_t                  rsp_status,
  // registered request, to decode and align
  output logic                         q_store,
  output funct3_t                      q_funct3,
  output addr_t                        q_addr,
  output word_t                        q_wdata,
  input  lsu_status_t                  dec_status,
  // memory bus
  output logic                         mem_valid,
  output logic                         mem_write,
  output logic [$clog2(MEM_WORDS)-1:0] mem_index,
  input  logic                         mem_ack,
  // read-data register strobes
  output logic                         ld_capture,
  output logic                         ld_clear
);

  localparam int unsigned IW = $clog2(MEM_WORDS); // word index width

  lsu_state_t state;
  logic       accept; // request handshake

  assign req_ready = (state == S_IDLE);
  assign accept    = req_valid & req_ready;

  ////////////////////////////////////////////////////////////////////////////
  // request register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept) begin
      q_store  <= req_store;
      q_funct3 <= req_funct3;
      q_addr   <= req_addr;
      q_wdata  <= req_wdata;
    end
  end

  assign mem_index = q_addr[IW+1:2];          // drop byte offset
  assign mem_write = mem_valid & q_store;

  ////////////////////////////////////////////////////////////////////////////
  // fsm
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state      <= S_IDLE;
      rsp_valid  <= 1'b0;
      rsp_status <= ST_OK;
      mem_valid  <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (req_valid) state <= S_ACCESS;   // request latched on this edge
        end
        S_ACCESS: begin
          if (!mem_valid) begin
            // check cycle, decode is looking at the fresh q_* fields
            if (dec_status != ST_OK) begin
              rsp_valid  <= 1'b1;             // fault path, no bus access
              rsp_status <= dec_status;
              state      <= S_RESPOND;
            end else begin
              mem_valid <= 1'b1;
            end
          end else if (mem_ack) begin
            mem_valid  <= 1'b0;               // strobe held until ack
            rsp_valid  <= 1'b1;
            rsp_status <= ST_OK;
            state      <= S_RESPOND;
          end
        end
        S_RESPOND: begin
          if (rsp_ready) begin
            rsp_valid <= 1'b0;
            state     <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // read data register strobes
  assign ld_capture = mem_valid & mem_ack & ~q_store; // load ack cycle only
  assign ld_clear   = accept;                         // zero for store/fault

endmodule

// ==== lsu/lsu_req_decode.sv ====
// combinational access check, store lane steering and byte-enable generation for the registered request
`timescale 1ns/100ps

module lsu_req_decode import lsu_pkg::*; (
  input  logic        q_store,
  input  funct3_t     q_funct3,
  input  addr_t       q_addr,
  input  word_t       q_wdata,
  output lsu_status_t dec_status,
  output ben_t        mem_ben,
  output word_t       mem_wdata
);

  boff_t boff;
  logic  legal;
  logic  misaligned;

  assign boff = q_addr[1:0];

  ////////////////////////////////////////////////////////////////////////////
  // access check
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (q_store) legal = q_funct3 inside {F3_B, F3_H, F3_W};
    else         legal = q_funct3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU};

    case (q_funct3)
      F3_H, F3_HU: misaligned = boff[0];
      F3_W:        misaligned = |boff;
      default:     misaligned = 1'b0;  // bytes always aligned
    endcase

    // illegal first
    if (!legal)          dec_status = ST_ILLEGAL;
    else if (misaligned) dec_status = ST_MISALIGNED;
    else                 dec_status = ST_OK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // store lanes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (!q_store) begin
      mem_ben   = 4'b1111;            // loads read the whole word
      mem_wdata = '0;
    end else begin
      case (q_funct3)
        F3_B: begin
          mem_ben   = ben_t'(4'b0001 << boff);
          mem_wdata = word_t'(q_wdata[7:0]) << {boff, 3'b000};
        end
        F3_H: begin
          mem_ben   = boff[1] ? 4'b1100 : 4'b0011;   // lower or upper half
          mem_wdata = word_t'(q_wdata[15:0]) << {boff[1], 4'b0000};
        end
        F3_W: begin
          mem_ben   = 4'b1111;
          mem_wdata = q_wdata;
        end
        default: begin
          mem_ben   = '0;             // illegal, never reaches the bus
          mem_wdata = '0;
        end
      endcase
    end
  end

endmodule

// ==== lsu/lsu_load_align.sv ====
// response data register, shifts the loaded word down and sign or zero extends it on capture
`timescale 1ns/100ps

module lsu_load_align import lsu_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    ld_capture, // load ack cycle
  input  logic    ld_clear,   // request accepted
  input  funct3_t funct3,
  input  boff_t   boff,
  input  word_t   mem_rdata,
  output word_t   rsp_rdata
);

  word_t aligned;

  ////////////////////////////////////////////////////////////////////////////
  // shift and extend
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : align_blk
    word_t tmp;
    tmp = mem_rdata >> {boff, 3'b000};   // selected byte/half to lane 0
    case (funct3)
      F3_B:    aligned = {{24{tmp[7]}}, tmp[7:0]};
      F3_H:    aligned = {{16{tmp[15]}}, tmp[15:0]};
      F3_BU:   aligned = {24'h000000, tmp[7:0]};
      F3_HU:   aligned = {16'h0000, tmp[15:0]};
      default: aligned = tmp;            // lw, offset is zero here
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // read data register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rsp_rdata <= '0;
    end else if (ld_clear) begin
      rsp_rdata <= '0;                   // stores and faults answer zero
    end else if (ld_capture) begin
      rsp_rdata <= aligned;
    end
  end

endmodule

// ==== hdl/data_ram.sv ====
// behavioral word RAM acting as bus slave, byte-enable writes and an acknowledge after a set wait
`timescale 1ns/100ps

module data_ram import lsu_pkg::*; #(
  parameter int unsigned MEM_WORDS   = 256, // depth in words
  parameter int unsigned WAIT_STATES = 2    // extra cycles before ack
)(
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         mem_valid,
  input  logic                         mem_write,
  input  logic [$clog2(MEM_WORDS)-1:0] mem_index,
  input  ben_t                         mem_ben,
  input  word_t                        mem_wdata,
  output logic                         mem_ack,
  output word_t                        mem_rdata
);

  // counter wide enough to reach WAIT_STATES, at least one bit
  localparam int unsigned CW = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  word_t         mem [MEM_WORDS];
  logic [CW-1:0] wait_cnt;
  logic          done;     // access completes on this edge

  assign done = mem_valid & ~mem_ack & (wait_cnt == CW'(WAIT_STATES));

  ////////////////////////////////////////////////////////////////////////////
  // wait counter and ack pulse
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wait_cnt <= '0;
      mem_ack  <= 1'b0;
    end else begin
      mem_ack <= done;                    // one cycle pulse
      if (!mem_valid || mem_ack || done) wait_cnt <= '0;  // restart per request
      else                               wait_cnt <= wait_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < MEM_WORDS; i++) mem[i] <= '0;
    end else if (done && mem_write) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_ben[b]) mem[mem_index][8*b +: 8] <= mem_wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (done && !mem_write) mem_rdata <= mem[mem_index]; // valid with ack
  end

endmodule

// ==== hdl/lsu_top.sv ====
// load/store unit top level, ties control, decode, align and the data RAM together
`timescale 1ns/100ps

module lsu_top import lsu_pkg::*; #(
  parameter int unsigned MEM_WORDS   = 256, // data memory depth in words
  parameter int unsigned WAIT_STATES = 2    // memory ack delay
)(
  input  logic        clk,
  input  logic        rst,
  // core request
  input  logic        req_valid,
  output logic        req_ready,
  input  logic        req_store,
  input  funct3_t     req_funct3,
  input  addr_t       req_addr,
  input  word_t       req_wdata,
  // core response
  output logic        rsp_valid,
  input  logic        rsp_ready,
  output lsu_status_t rsp_status,
  output word_t       rsp_rdata
);

  localparam int unsigned IW = $clog2(MEM_WORDS);

  ////////////////////////////////////////////////////////////////////////////
  // internal wires
  ////////////////////////////////////////////////////////////////////////////

  logic          q_store;
  funct3_t       q_funct3;
  addr_t         q_addr;
  word_t         q_wdata;
  lsu_status_t   dec_status;
  logic          ld_capture;
  logic          ld_clear;
  // memory bus
  logic          mem_valid;
  logic          mem_write;
  logic [IW-1:0] mem_index;
  ben_t          mem_ben;
  word_t         mem_wdata;
  logic          mem_ack;
  word_t         mem_rdata;

  lsu_ctrl #(
    .MEM_WORDS (MEM_WORDS)
  ) u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_store  (req_store),
    .req_funct3 (req_funct3),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp_status (rsp_status),
    .q_store    (q_store),
    .q_funct3   (q_funct3),
    .q_addr     (q_addr),
    .q_wdata    (q_wdata),
    .dec_status (dec_status),
    .mem_valid  (mem_valid),
    .mem_write  (mem_write),
    .mem_index  (mem_index),
    .mem_ack    (mem_ack),
    .ld_capture (ld_capture),
    .ld_clear   (ld_clear)
  );

  lsu_req_decode u_decode (
    .q_store    (q_store),
    .q_funct3   (q_funct3),
    .q_addr     (q_addr),
    .q_wdata    (q_wdata),
    .dec_status (dec_status),
    .mem_ben    (mem_ben),
    .mem_wdata  (mem_wdata)
  );

  lsu_load_align u_align (
    .clk        (clk),
    .rst        (rst),
    .ld_capture (ld_capture),
    .ld_clear   (ld_clear),
    .funct3     (q_funct3),
    .boff       (q_addr[1:0]),  // byte offset of the load
    .mem_rdata  (mem_rdata),
    .rsp_rdata  (rsp_rdata)
  );

  data_ram #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) u_ram (
    .clk        (clk),
    .rst        (rst),
    .mem_valid  (mem_valid),
    .mem_write  (mem_write),
    .mem_index  (mem_index),
    .mem_ben    (mem_ben),
    .mem_wdata  (mem_wdata),
    .mem_ack    (mem_ack),
    .mem_rdata  (mem_rdata)
  );

endmodule

// ==== verif/lsu_tb.sv ====
// table-driven testbench for the load/store unit, throttles rsp_ready and checks every response
`timescale 1ns/100ps

module lsu_tb
  import lsu_pkg::*;
();

  localparam int WAIT_STATES     = 2;  // dut runs with its default
  localparam int RESET_CYCLES    = 4;
  localparam int THROTTLE_CYCLES = 16; // slack per entry for rsp_ready stalls
  localparam logic LOAD  = 1'b0;
  localparam logic STORE = 1'b1;

  // one table row, stimulus then expected response
  typedef struct packed {
    logic        store;
    funct3_t     funct3;
    addr_t       addr;
    word_t       wdata;
    lsu_status_t status;
    word_t       rdata;
  } vec_t;

  logic        clk;
  logic        rst;
  logic        req_valid;
  logic        req_ready;
  logic        req_store;
  funct3_t     req_funct3;
  addr_t       req_addr;
  word_t       req_wdata;
  logic        rsp_valid;
  logic        rsp_ready;
  lsu_status_t rsp_status;
  word_t       rsp_rdata;

  vec_t   table_q[$];
  integer seed;
  int     entry_errs;   // errors in the running entry
  int     extra_errs;   // failures outside any entry
  int     n_pass;
  int     n_fail;
  int     n_rsp;        // responses seen on the port
  logic   rsp_seen;     // rsp_valid at the previous falling edge
  int     stall_cycles; // cycles with rsp_valid held against rsp_ready low
  int     cycles;
  int     limit;

  lsu_top dut (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_store  (req_store),
    .req_funct3 (req_funct3),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp_status (rsp_status),
    .rsp_rdata  (rsp_rdata)
  );

  always #2 clk = ~clk; // 4 ns period

  ////////////////////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("run timed out waiting for a handshake after %0d cycles", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // every rise of rsp_valid is one response, a drop and rise counts twice
  always @(negedge clk) begin
    if (rsp_valid && !rsp_seen) n_rsp++;
    rsp_seen = rsp_valid;
  end

  task automatic add_vec(input logic store, input funct3_t f3, input addr_t addr,
                         input word_t wdata, input lsu_status_t status, input word_t rdata);
    vec_t v;
    v = '{store, f3, addr, wdata, status, rdata};
    table_q.push_back(v);
  endtask

  // holds the request until req_ready, drops it after the accepting edge
  task automatic send_request(input vec_t v);
    req_valid  = 1'b1;
    req_store  = v.store;
    req_funct3 = v.funct3;
    req_addr   = v.addr;
    req_wdata  = v.wdata;
    while (!req_ready) @(negedge clk);
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic collect_response(input int idx, output lsu_status_t st, output word_t rd);
    logic        held;    // response already seen last cycle
    lsu_status_t held_st;
    word_t       held_rd;
    logic        taken;
    held    = 1'b0;
    held_st = ST_OK;
    held_rd = '0;
    taken   = 1'b0;
    st      = ST_OK;
    rd      = '0;
    while (!taken) begin
      @(negedge clk);
      rsp_ready = (($random(seed) & 3) != 0);  // ready three cycles in four
      if (rsp_valid) begin
        assert (!req_ready) else begin
          $display("ERROR t=%0t entry %0d: req_ready high with response pending", $time, idx);
          entry_errs++;
        end
        if (held) begin
          assert (rsp_status == held_st && rsp_rdata == held_rd) else begin
            $display("ERROR t=%0t entry %0d: response changed while stalled", $time, idx);
            entry_errs++;
          end
        end
        held    = 1'b1;
        held_st = rsp_status;
        held_rd = rsp_rdata;
        if (rsp_ready) begin
          taken = 1'b1;             // transfer on the coming edge
          st    = rsp_status;
          rd    = rsp_rdata;
        end else begin
          stall_cycles++;
        end
      end
    end
    @(negedge clk);
    rsp_ready = 1'b0;
    assert (!rsp_valid && req_ready) else begin
      $display("ERROR t=%0t entry %0d: unit not idle after response", $time, idx);
      entry_errs++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_table();
    // word round trip, store answers zero
    add_vec(STORE, F3_W,  32'h010, 32'hdead_beef, ST_OK, 32'h0000_0000);
    add_vec(LOAD,  F3_W,  32'h010, 32'h0,         ST_OK, 32'hdead_beef);
    // partial stores merge into existing words
    add_vec(STORE, F3_W,  32'h020, 32'h1122_3344, ST_OK, 32'h0000_0000);
    add_vec(STORE, F3_B,  32'h021, 32'hffff_ffaa, ST_OK, 32'h0000_0000);
    add_vec(STORE, F3_B,  32'h023, 32'h0000_00bb, ST_OK, 32'h0000_0000);
    add_vec(LOAD,  F3_W,  32'h020, 32'h0,         ST_OK, 32'hbb22_aa44);
    add_vec(STORE, F3_W,  32'h030, 32'h5566_7788, ST_OK, 32'h0000_0000);
    add_vec(STORE, F3_H,  32'h032, 32'h1234_abcd, ST_OK, 32'h0000_0000);
    add_vec(LOAD,  F3_W,  32'h030, 32'h0,         ST_OK, 32'habcd_7788);
    // extension, bytes 8e 7f f1 80 from lane 0 up
    add_vec(STORE, F3_W,  32'h040, 32'h80f1_7f8e, ST_OK, 32'h0000_0000);
    add_vec(LOAD,  F3_B,  32'h040, 32'h0,         ST_OK, 32'hffff_ff8e);
    add_vec(LOAD,  F3_B,  32'h041, 32'h0,         ST_OK, 32'h0000_007f);
    add_vec(LOAD,  F3_B,  32'h042, 32'h0,         ST_OK, 32'hffff_fff1);
    add_vec(LOAD,  F3_B,  32'h043, 32'h0,         ST_OK, 32'hffff_ff80);
    add_vec(LOAD,  F3_BU, 32'h040, 32'h0,         ST_OK, 32'h0000_008e);
    add_vec(LOAD,  F3_BU, 32'h041, 32'h0,         ST_OK, 32'h0000_007f);
    add_vec(LOAD,  F3_BU, 32'h042, 32'h0,         ST_OK, 32'h0000_00f1);
    add_vec(LOAD,  F3_BU, 32'h043, 32'h0,         ST_OK, 32'h0000_0080);
    add_vec(LOAD,  F3_H,  32'h040, 32'h0,         ST_OK, 32'h0000_7f8e);
    add_vec(LOAD,  F3_H,  32'h042, 32'h0,         ST_OK, 32'hffff_80f1);
    add_vec(LOAD,  F3_HU, 32'h040, 32'h0,         ST_OK, 32'h0000_7f8e);
    add_vec(LOAD,  F3_HU, 32'h042, 32'h0,         ST_OK, 32'h0000_80f1);
    // misaligned, memory must stay untouched
    add_vec(LOAD,  F3_H,  32'h041, 32'h0,         ST_MISALIGNED, 32'h0);
    add_vec(STORE, F3_W,  32'h011, 32'h1234_5678, ST_MISALIGNED, 32'h0);
    add_vec(STORE, F3_W,  32'h012, 32'h1234_5678, ST_MISALIGNED, 32'h0);
    add_vec(STORE, F3_W,  32'h013, 32'h1234_5678, ST_MISALIGNED, 32'h0);
    add_vec(LOAD,  F3_W,  32'h010, 32'h0,         ST_OK, 32'hdead_beef);
    // illegal codes, some with a misaligned address too
    add_vec(LOAD,  3'd3,  32'h010, 32'h0,         ST_ILLEGAL, 32'h0);
    add_vec(LOAD,  3'd6,  32'h010, 32'h0,         ST_ILLEGAL, 32'h0);
    add_vec(LOAD,  3'd7,  32'h010, 32'h0,         ST_ILLEGAL, 32'h0);
    add_vec(STORE, 3'd3,  32'h010, 32'hcafe_f00d, ST_ILLEGAL, 32'h0);
    add_vec(STORE, 3'd4,  32'h010, 32'hcafe_f00d, ST_ILLEGAL, 32'h0);
    add_vec(STORE, 3'd5,  32'h010, 32'hcafe_f00d, ST_ILLEGAL, 32'h0);
    add_vec(STORE, 3'd6,  32'h010, 32'hcafe_f00d, ST_ILLEGAL, 32'h0);
    add_vec(STORE, 3'd7,  32'h010, 32'hcafe_f00d, ST_ILLEGAL, 32'h0);
    add_vec(LOAD,  3'd7,  32'h013, 32'h0,         ST_ILLEGAL, 32'h0);
    add_vec(STORE, 3'd5,  32'h011, 32'hcafe_f00d, ST_ILLEGAL, 32'h0); // halfword code, odd
    add_vec(LOAD,  F3_W,  32'h010, 32'h0,         ST_OK, 32'hdead_beef);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    lsu_status_t got_st;
    word_t       got_rd;
    vec_t        v;
    clk          = 1'b0;
    rst          = 1'b1;
    req_valid    = 1'b0;
    req_store    = 1'b0;
    req_funct3   = F3_W;
    req_addr     = '0;
    req_wdata    = '0;
    rsp_ready    = 1'b0;
    seed         = 32'h46ee_6d99;
    entry_errs   = 0;
    extra_errs   = 0;
    n_pass       = 0;
    n_fail       = 0;
    n_rsp        = 0;
    rsp_seen     = 1'b0;
    stall_cycles = 0;
    cycles       = 0;
    build_table();
    limit = table_q.size() * (WAIT_STATES + 3 + THROTTLE_CYCLES) + RESET_CYCLES;

    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    assert (req_ready && !rsp_valid && rsp_rdata == '0) else begin
      $display("ERROR t=%0t: outputs not at their idle values after reset", $time);
      extra_errs++;
    end

    for (int i = 0; i < table_q.size(); i++) begin
      v          = table_q[i];
      entry_errs = 0;
      send_request(v);
      collect_response(i, got_st, got_rd);
      assert (got_st == v.status) else begin
        $display("ERROR t=%0t entry %0d: status %0d, expected %0d",
                 $time, i, got_st, v.status);
        entry_errs++;
      end
      assert (got_rd == v.rdata) else begin
        $display("ERROR t=%0t entry %0d: rdata %h, expected %h", $time, i, got_rd, v.rdata);
        entry_errs++;
      end
      if (entry_errs == 0) n_pass++;
      else                 n_fail++;
      $display("entry %0d %s f3=%0d addr=%h: status %0d rdata %h %s", i,
               v.store ? "store" : "load", v.funct3, v.addr, got_st, got_rd,
               (entry_errs == 0) ? "ok" : "mismatch");
    end

    // one response per request
    assert (n_rsp == table_q.size()) else begin
      $display("got %0d responses for %0d requests", n_rsp, table_q.size());
      extra_errs++;
    end
    assert (stall_cycles > 0) else begin
      $display("rsp_ready throttle never stalled a response, back-pressure untested");
      extra_errs++;
    end

    $display("tests passed %0d, failed %0d, other errors %0d", n_pass, n_fail, extra_errs);
    if (n_fail == 0 && extra_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
common/lsu_pkg.sv
lsu/lsu_ctrl.sv
lsu/lsu_req_decode.sv
lsu/lsu_load_align.sv
hdl/data_ram.sv
hdl/lsu_top.sv
verif/lsu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the load/store unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb -f files.f

out=$(./obj_dir/Vlsu_tb)
echo "$out"

if echo "$out" | grep -qx "Simulation PASSED"; then
  exit 0
else
  exit 1
fi
